//--- verilog/windowPkg.sv
// ==============================
// Window package
// Sample and window index types
// ==============================

package windowPkg;

  // Sample width in bits, samples are unsigned fractions
  localparam int DATA_W = 8;

  // Window length in samples
  // Power of 2, at least 8
  localparam int WINLEN = 64;

  // Width of the wrapping time index t
  localparam int WINLEN_W = $clog2(WINLEN);

  // One sample, raw or windowed
  typedef logic [DATA_W-1:0] sample_t;

  // Time index, also the sample RAM address
  typedef logic [WINLEN_W-1:0] winIdx_t;

endpackage

//--- verilog/memPkg.sv
// ==============================
// Sample RAM package
// Request and response structs
// ==============================

package memPkg;

  // One request to the sample RAM
  // req qualifies the whole struct
  // write selects store or fetch
  typedef struct packed {
    logic                req;
    logic                write;
    windowPkg::winIdx_t  addr;
    windowPkg::sample_t  data;
  } memReq_t;

  // One read response, one cycle after the read request
  typedef struct packed {
    logic                valid;
    windowPkg::sample_t  data;
  } memRsp_t;

endpackage

//--- verilog/fxcs.sv
// ==============================
// Highest set bit finder
// Masked vector to one-hot MSB
// ==============================

`timescale 1ns/1ps

module fxcs #(
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0] i_target,
  input  logic [WIDTH-1:0] i_vector,
  output logic [WIDTH-1:0] o_onehot
);

  // Candidate bits after masking
  logic [WIDTH-1:0] masked;
  // Set once a higher candidate has been seen
  logic             seenHigher;

  assign masked = i_vector & i_target;

  // Walk down from the MSB and keep the first set bit only
  always_comb begin
    seenHigher = 1'b0;
    o_onehot = '0;
    for (int i = WIDTH - 1; i >= 0; i--) begin
      o_onehot[i] = masked[i] & ~seenHigher;
      seenHigher = seenHigher | masked[i];
    end
  end

endmodule

//--- verilog/onehotIdx.sv
// ==============================
// One-hot to index encoder
// ==============================

`timescale 1ns/1ps

module onehotIdx #(
  // At least 2, so the index has one bit or more
  parameter int WIDTH = 8
) (
  input  logic [WIDTH-1:0]         i_onehot,
  output logic [$clog2(WIDTH)-1:0] o_index,
  output logic                     o_valid
);

  localparam int IDX_W = $clog2(WIDTH);

  // OR the positions of the set bits together
  // Exact only for a true one-hot input
  always_comb begin
    o_index = '0;
    for (int i = 0; i < WIDTH; i++) begin
      if (i_onehot[i]) begin
        o_index = o_index | IDX_W'(i);
      end
    end
  end

  // Index 0 is ambiguous without this flag
  assign o_valid = |i_onehot;

endmodule

//--- verilog/logdropWindow.sv
// ==============================
// Logdrop window multiply
// y = x * w(t), w a power of 2
// Gate model or integer model
// ==============================

`timescale 1ns/1ps

module logdropWindow #(
  parameter int DATA_W         = 8,
  // Power of 2, at least 8
  parameter int WINLEN         = 64,
  parameter bit ABSTRACT_MODEL = 1'b0
) (
  // Wrapping time index
  input  logic [$clog2(WINLEN)-1:0] i_t,
  input  logic [DATA_W-1:0]         i_x,
  output logic [DATA_W-1:0]         o_y
);

  if (ABSTRACT_MODEL) begin : abstractModel

    // Integer form of the window rule
    int tPlus;
    int a;
    int shift;

    always_comb begin
      // 1-indexed time
      tPlus = int'(i_t) + 1;
      // min(t+1, WINLEN-t), rises then falls across the frame
      if (tPlus <= WINLEN - tPlus + 1) begin
        a = tPlus;
      end else begin
        a = WINLEN - tPlus + 1;
      end
      // WINLEN is a power of 2, so clog2 of WINLEN/2 is the exact log
      shift = $clog2(WINLEN / 2) - $clog2(a);
    end

    assign o_y = i_x >> shift;

  end else begin : gateModel

    localparam int WINLEN_W     = $clog2(WINLEN);
    // Sawtooth drops the top bit of t
    localparam int SAW_W        = WINLEN_W - 1;
    localparam int ONEHOT_IDX_W = $clog2(SAW_W);
    // Mux select spans 0 to SAW_W
    localparam int MUXIDX_W     = $clog2(WINLEN_W);

    logic                    lastHalf;
    logic [SAW_W-1:0]        saw;
    logic [SAW_W-1:0]        sawMsb;
    logic [ONEHOT_IDX_W-1:0] sawMsbIdx;
    logic                    sawMsbVld;
    logic [MUXIDX_W-1:0]     muxIdx;
    logic [DATA_W-1:0]       shifted [WINLEN_W];

    assign lastHalf = i_t[WINLEN_W-1];

    // Counts up over the first half, back down over the second
    // Equals min(t+1, WINLEN-t) - 1
    assign saw = lastHalf ? ~i_t[SAW_W-1:0] : i_t[SAW_W-1:0];

    // Highest set bit of the sawtooth
    fxcs #(
      .WIDTH (SAW_W)
    ) onlyMsb_u (
      .i_target ({SAW_W{1'b1}}),
      .i_vector (saw),
      .o_onehot (sawMsb)
    );

    // Its position, invalid when the sawtooth is zero
    onehotIdx #(
      .WIDTH (SAW_W)
    ) msbIdx_u (
      .i_onehot (sawMsb),
      .o_index  (sawMsbIdx),
      .o_valid  (sawMsbVld)
    );

    // ceil(log2(saw+1)), zero at both ends of the frame
    assign muxIdx = MUXIDX_W'(sawMsbIdx) + MUXIDX_W'(sawMsbVld);

    // Tap i is x scaled by 2**(i - SAW_W)
    for (genvar i = 0; i < WINLEN_W; i++) begin : shiftTap
      assign shifted[i] = i_x >> (SAW_W - i);
    end

    assign o_y = shifted[muxIdx];

  end

endmodule

//--- verilog/windowSequencer.sv
// ==============================
// Window sequencer
// Windows each sample at time t
// and issues its RAM write
// ==============================

`timescale 1ns/1ps

module windowSequencer #(
  parameter bit ABSTRACT_MODEL = 1'b0
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_sampleStrobe,
  input  windowPkg::sample_t i_sample,
  output memPkg::memReq_t    o_wrReq,
  output logic               o_frameDone
);

  // Time index of the next sample
  windowPkg::winIdx_t t;
  // Incoming sample after the window
  windowPkg::sample_t windowed;

  // Registered write request
  logic               wrValid;
  windowPkg::winIdx_t wrAddr;
  windowPkg::sample_t wrData;

  logdropWindow #(
    .DATA_W         (windowPkg::DATA_W),
    .WINLEN         (windowPkg::WINLEN),
    .ABSTRACT_MODEL (ABSTRACT_MODEL)
  ) window_u (
    .i_t (t),
    .i_x (i_sample),
    .o_y (windowed)
  );

  // Control, one write and at most one frame end per strobe
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      t <= '0;
      wrValid <= 1'b0;
      o_frameDone <= 1'b0;
    end else begin
      wrValid <= i_sampleStrobe;
      // All ones is the last index of the frame
      o_frameDone <= i_sampleStrobe & (&t);
      if (i_sampleStrobe) begin
        // Wraps at WINLEN by overflow
        t <= t + 1'b1;
      end
    end
  end

  // Address and data captured with the strobe
  always_ff @(posedge i_clk) begin
    if (i_sampleStrobe) begin
      wrAddr <= t;
      wrData <= windowed;
    end
  end

  assign o_wrReq = '{req: wrValid, write: 1'b1, addr: wrAddr, data: wrData};

endmodule

//--- verilog/frameReader.sv
// ==============================
// Host read port
// One pending read at a time
// ==============================

`timescale 1ns/1ps

module frameReader (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_rdStrobe,
  input  windowPkg::winIdx_t i_rdAddr,
  output memPkg::memReq_t    o_rdReq,
  input  logic               i_rdGrant,
  input  memPkg::memRsp_t    i_ramRsp,
  output logic               o_rdValid,
  output windowPkg::sample_t o_rdData
);

  // Request waiting for the arbiter
  logic               pending;
  // Granted last cycle, RAM data arrives now
  logic               waitRsp;
  windowPkg::winIdx_t rdAddr;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pending <= 1'b0;
      waitRsp <= 1'b0;
    end else begin
      // Held until granted, writes may push it back
      if (i_rdStrobe) begin
        pending <= 1'b1;
      end else if (i_rdGrant) begin
        pending <= 1'b0;
      end
      waitRsp <= pending & i_rdGrant;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rdStrobe) begin
      rdAddr <= i_rdAddr;
    end
  end

  assign o_rdReq = '{req: pending, write: 1'b0, addr: rdAddr, data: '0};

  // Only take the RAM response that belongs to our read
  assign o_rdValid = waitRsp & i_ramRsp.valid;
  assign o_rdData  = i_ramRsp.data;

endmodule

//--- verilog/memArbiter.sv
// ==============================
// Sample RAM arbiter
// Fixed priority, writes first
// ==============================

`timescale 1ns/1ps

module memArbiter (
  input  logic            i_clk,
  input  logic            i_rst,
  input  memPkg::memReq_t i_wrReq,
  input  memPkg::memReq_t i_rdReq,
  output logic            o_rdGrant,
  output memPkg::memReq_t o_ramReq
);

  // Reader owns the RAM response in the cycle after its grant
  logic rdInFlight;

  // Sequencer writes never wait
  // A read waits behind any write and behind its own response
  assign o_rdGrant = i_rdReq.req & ~i_wrReq.req & ~rdInFlight;

  // Single port, so exactly one request reaches the RAM
  always_comb begin
    o_ramReq = '0;
    if (i_wrReq.req) begin
      o_ramReq = i_wrReq;
    end else if (o_rdGrant) begin
      o_ramReq = i_rdReq;
    end
  end

  // Track the read whose data is on the RAM output next
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      rdInFlight <= 1'b0;
    end else begin
      rdInFlight <= o_rdGrant;
    end
  end

endmodule

//--- verilog/sampleRam.sv
// ==============================
// Windowed sample RAM
// Single port, 1-cycle read
// ==============================

`timescale 1ns/1ps

module sampleRam (
  input  logic            i_clk,
  input  memPkg::memReq_t i_ramReq,
  output memPkg::memRsp_t o_ramRsp
);

  windowPkg::sample_t mem [windowPkg::WINLEN];

  logic               rspValid;
  windowPkg::sample_t rspData;

  always_ff @(posedge i_clk) begin
    rspValid <= i_ramReq.req & ~i_ramReq.write;
    if (i_ramReq.req && i_ramReq.write) begin
      mem[i_ramReq.addr] <= i_ramReq.data;
    end
    // Data register only moves on a read
    if (i_ramReq.req && !i_ramReq.write) begin
      rspData <= mem[i_ramReq.addr];
    end
  end

  assign o_ramRsp = '{valid: rspValid, data: rspData};

endmodule

//--- verilog/windowFrameTop.sv
// ==============================
// Window frame capture top
// Sequencer and host reader
// sharing one sample RAM
// ==============================

`timescale 1ns/1ps

module windowFrameTop #(
  parameter bit ABSTRACT_MODEL = 1'b0
) (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_sampleStrobe,
  input  windowPkg::sample_t i_sample,
  input  logic               i_rdStrobe,
  input  windowPkg::winIdx_t i_rdAddr,
  output logic               o_rdValid,
  output windowPkg::sample_t o_rdData,
  output logic               o_frameDone
);

  memPkg::memReq_t wrReq;
  memPkg::memReq_t rdReq;
  memPkg::memReq_t ramReq;
  memPkg::memRsp_t ramRsp;
  logic            rdGrant;

  windowSequencer #(
    .ABSTRACT_MODEL (ABSTRACT_MODEL)
  ) sequencer_u (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_sampleStrobe (i_sampleStrobe),
    .i_sample       (i_sample),
    .o_wrReq        (wrReq),
    .o_frameDone    (o_frameDone)
  );

  frameReader reader_u (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rdStrobe (i_rdStrobe),
    .i_rdAddr   (i_rdAddr),
    .o_rdReq    (rdReq),
    .i_rdGrant  (rdGrant),
    .i_ramRsp   (ramRsp),
    .o_rdValid  (o_rdValid),
    .o_rdData   (o_rdData)
  );

  memArbiter arbiter_u (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_wrReq   (wrReq),
    .i_rdReq   (rdReq),
    .o_rdGrant (rdGrant),
    .o_ramReq  (ramReq)
  );

  sampleRam ram_u (
    .i_clk    (i_clk),
    .i_ramReq (ramReq),
    .o_ramRsp (ramRsp)
  );

endmodule

//--- tests/windowFrame_props.sv
// ==============================
// Window frame properties
// Bound into the top level
// ==============================

`timescale 1ns/1ps

module windowFrame_props (
  input logic            i_clk,
  input logic            i_rst,
  input memPkg::memReq_t i_wrReq,
  input memPkg::memReq_t i_rdReq,
  input memPkg::memReq_t i_ramReq,
  input logic            i_rdStrobe,
  input logic            i_frameDone,
  input logic            i_rdValid
);

  // Set by a failing property
  logic collideFail = 1'b0;
  logic doneFail = 1'b0;
  logic rdValidFail = 1'b0;

  // Host read open from its strobe until its data
  logic hostRdOpen;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      hostRdOpen <= 1'b0;
    end else if (i_rdStrobe) begin
      hostRdOpen <= 1'b1;
    end else if (i_rdValid) begin
      hostRdOpen <= 1'b0;
    end
  end

  // Single port, a read reaches the RAM only in a cycle without a write
  noCollision: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_ramReq.req && !i_ramReq.write) |->
      (!i_wrReq.req && i_ramReq.addr == i_rdReq.addr))
  else begin
    $error("Write and read requests reached the RAM in the same cycle");
    collideFail = 1'b1;
  end

  // Frame end is a single-cycle pulse
  donePulse: assert property (@(posedge i_clk) disable iff (i_rst)
    i_frameDone |=> !i_frameDone)
  else begin
    $error("Frame done stayed high for more than one cycle");
    doneFail = 1'b1;
  end

  // Read data only answers a host read that is still open
  rdValidCause: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rdValid |-> hostRdOpen)
  else begin
    $error("Read valid rose without a pending read");
    rdValidFail = 1'b1;
  end

endmodule

bind windowFrameTop windowFrame_props props_u (
  .i_clk       (i_clk),
  .i_rst       (i_rst),
  .i_wrReq     (wrReq),
  .i_rdReq     (rdReq),
  .i_ramReq    (ramReq),
  .i_rdStrobe  (i_rdStrobe),
  .i_frameDone (o_frameDone),
  .i_rdValid   (o_rdValid)
);

//--- tests/windowFrameTb.sv
// ==============================
// Window frame testbench
// Random and all-ones frames,
// reads during capture, reset
// ==============================

`timescale 1ns/1ps

module windowFrameTb;

  localparam int WINLEN = windowPkg::WINLEN;
  // Three frames and the reset test, two full readbacks and the rest
  localparam int NUM_SAMPLES = 3 * WINLEN + 6;
  localparam int NUM_READS = 2 * WINLEN + 14;
  localparam int WATCHDOG_CYCLES = (NUM_SAMPLES + NUM_READS) * 20;

  logic               clk;
  logic               rst;
  logic               sampleStrobe;
  windowPkg::sample_t sample;
  logic               rdStrobe;
  windowPkg::winIdx_t rdAddr;
  logic               rdValid;
  windowPkg::sample_t rdData;
  logic               frameDone;

  // Expected RAM contents, expected t and samples in this frame
  windowPkg::sample_t stored [WINLEN];
  windowPkg::winIdx_t nextIdx;
  int                 inFrame;
  int                 doneCount = 0;

  windowFrameTop #(
    .ABSTRACT_MODEL (1'b0)
  ) i_dut (
    .i_clk          (clk),
    .i_rst          (rst),
    .i_sampleStrobe (sampleStrobe),
    .i_sample       (sample),
    .i_rdStrobe     (rdStrobe),
    .i_rdAddr       (rdAddr),
    .o_rdValid      (rdValid),
    .o_rdData       (rdData),
    .o_frameDone    (frameDone)
  );

  always #10 clk = ~clk;

  // Count frame end pulses, each one right after index WINLEN-1
  always @(posedge clk) begin
    if (!rst && frameDone) begin
      doneCount <= doneCount + 1;
      checkValue("frameDoneIndex", 0, int'(nextIdx));
    end
  end

  function automatic logic propertyFailed();
    return i_dut.props_u.collideFail | i_dut.props_u.doneFail |
           i_dut.props_u.rdValidFail;
  endfunction

  task automatic abortRun(string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped");
  endtask

  // Bound assertions are caught half a cycle after they fire
  always @(negedge clk) begin
    if (propertyFailed()) begin
      abortRun("A bound property assertion failed");
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abortRun("Watchdog expired before all tests finished");
  end

  // Expected output of the logdrop window for index t
  function automatic windowPkg::sample_t windowRef(int t, windowPkg::sample_t x);
    int a;
    int halfLog;
    int ceilLog;
    a = (t + 1 < WINLEN - t) ? t + 1 : WINLEN - t;
    halfLog = 0;
    while ((1 << halfLog) < WINLEN / 2) begin
      halfLog++;
    end
    // Ceiling of log2(a)
    ceilLog = 0;
    while ((1 << ceilLog) < a) begin
      ceilLog++;
    end
    return x >> (halfLog - ceilLog);
  endfunction

  task automatic checkValue(string name, int exp, int got);
    assert (exp == got) else begin
      abortRun($sformatf("[ERROR] %s expected %0h actual %0h", name, exp, got));
    end
  endtask

  // One strobe, then an idle gap of 1 to 4 cycles
  task automatic sendSample(windowPkg::sample_t x);
    int gap;
    gap = 1 + int'($urandom % 4);
    @(posedge clk);
    sampleStrobe <= 1'b1;
    sample <= x;
    stored[nextIdx] = windowRef(int'(nextIdx), x);
    nextIdx = windowPkg::winIdx_t'(int'(nextIdx) + 1);
    inFrame++;
    @(posedge clk);
    sampleStrobe <= 1'b0;
    repeat (gap) @(posedge clk);
  endtask

  task automatic readCheck(string name, windowPkg::winIdx_t addr,
                           windowPkg::sample_t exp, output windowPkg::sample_t got);
    int waited;
    waited = 0;
    @(posedge clk);
    rdStrobe <= 1'b1;
    rdAddr <= addr;
    @(posedge clk);
    rdStrobe <= 1'b0;
    // Writes may delay the grant
    do begin
      @(posedge clk);
      waited++;
    end while (!rdValid && waited < 20);
    if (!rdValid) begin
      abortRun($sformatf("Read of address %0d in %s never completed", addr, name));
    end
    got = rdData;
    checkValue(name, int'(exp), int'(got));
  endtask

  task automatic sendFrame(logic allOnes);
    inFrame = 0;
    for (int i = 0; i < WINLEN; i++) begin
      sendSample(allOnes ? 8'hFF : windowPkg::sample_t'($urandom));
    end
    // Let the last write and frame done settle
    repeat (3) @(posedge clk);
  endtask

  initial begin
    windowPkg::sample_t ones [WINLEN];
    windowPkg::sample_t got;
    void'($urandom(39));
    clk = 1'b0;
    rst = 1'b1;
    sampleStrobe = 1'b0;
    sample = '0;
    rdStrobe = 1'b0;
    rdAddr = '0;
    nextIdx = '0;
    inFrame = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    // Full random frame, then every address read back
    sendFrame(1'b0);
    checkValue("frameDoneCount", 1, doneCount);
    for (int a = 0; a < WINLEN; a++) begin
      readCheck("randomFrame", windowPkg::winIdx_t'(a), stored[a], got);
    end

    // All ones overwrites the first frame with the coefficients
    sendFrame(1'b1);
    checkValue("frameDoneCount", 2, doneCount);
    for (int a = 0; a < WINLEN; a++) begin
      readCheck("allOnesFrame", windowPkg::winIdx_t'(a), stored[a], ones[a]);
    end
    checkValue("allOnesCentre", 255, int'(ones[WINLEN / 2]));
    for (int i = 0; i < WINLEN / 2; i++) begin
      checkValue("allOnesSymmetry", int'(ones[i]), int'(ones[WINLEN - 1 - i]));
    end
    for (int i = 0; i < WINLEN / 2 - 1; i++) begin
      assert (ones[i] <= ones[i + 1]) else begin
        abortRun("Coefficients do not rise from the ends toward the centre");
      end
    end

    // Reads behind and ahead of t while a frame is captured
    fork
      sendFrame(1'b0);
      begin : readerProc
        windowPkg::winIdx_t addr;
        windowPkg::sample_t seen;
        while (inFrame < 8) begin
          @(posedge clk);
        end
        for (int k = 0; k < 12; k++) begin
          addr = windowPkg::winIdx_t'(int'(nextIdx) + ((k % 2 == 0) ? -4 : 8));
          readCheck("readDuringCapture", addr, stored[addr], seen);
        end
      end
    join
    checkValue("frameDoneCount", 3, doneCount);

    // Reset after 5 samples, the next sample lands at address 0
    for (int i = 0; i < 5; i++) begin
      sendSample(8'h00);
    end
    rst <= 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    nextIdx = '0;
    inFrame = 0;
    sendSample(8'hA5);
    repeat (3) @(posedge clk);
    readCheck("resetMidFrame", '0, stored[0], got);
    readCheck("resetMidFrame", windowPkg::winIdx_t'(5), stored[5], got);
    checkValue("frameDoneCount", 3, doneCount);

    if (propertyFailed()) begin
      abortRun("A bound property assertion failed");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

//--- compile.f
verilog/windowPkg.sv
verilog/memPkg.sv
verilog/fxcs.sv
verilog/onehotIdx.sv
verilog/logdropWindow.sv
verilog/windowSequencer.sv
verilog/frameReader.sv
verilog/memArbiter.sv
verilog/sampleRam.sv
verilog/windowFrameTop.sv
tests/windowFrame_props.sv
tests/windowFrameTb.sv

//--- Makefile
# Verilator build and run of the window frame testbench

SIM  := obj_dir/VwindowFrameTb
SRCS := $(shell grep -v '^+' compile.f)

.PHONY: all run clean

all: $(SIM)

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module windowFrameTb -f compile.f

run: $(SIM)
	./$(SIM) +verilator+error+limit+100

clean:
	rm -rf obj_dir
